// ==== source/mipsPkg.sv ====
package mipsPkg;

    //////////////////////////////////////////////////
    // Memory sizes
    //////////////////////////////////////////////////
    localparam int imemWords    = 64;
    localparam int dmemWords    = 64;
    localparam int imemAddrBits = 6;

    //////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////
    typedef enum logic [5:0] {
        opRtype = 6'd0,
        opJ     = 6'd2,
        opBeq   = 6'd4,
        opBne   = 6'd5,
        opAddi  = 6'd8,
        opLw    = 6'd35,
        opSw    = 6'd43
    } opcode_t;

    typedef enum logic [5:0] {
        fnAdd = 6'd32,
        fnSub = 6'd34,
        fnAnd = 6'd36,
        fnOr  = 6'd37,
        fnSlt = 6'd42
    } funct_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp_t;

    // Control bits carried down the pipe
    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   aluSrcImm;
        aluOp_t aluOp;
    } ctrl_t;

    //////////////////////////////////////////////////
    // Stage registers
    //////////////////////////////////////////////////
    typedef struct packed {
        logic        valid;
        logic [31:0] pcPlus4;
        logic [31:0] instr;
    } ifId_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] rdA;
        logic [31:0] rdB;
        logic [31:0] imm;
        logic [4:0]  dest;
    } idEx_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] aluResult;
        logic [31:0] storeData;
        logic [4:0]  dest;
    } exMem_t;

    typedef struct packed {
        logic        valid;
        logic        regWrite;
        logic [4:0]  dest;
        logic [31:0] result;
    } memWb_t;

endpackage

// ==== source/hazardIf.sv ====
`timescale 1ns/1ns

interface hazardIf;

    // Register sources read in decode
    logic [4:0] srcA;
    logic [4:0] srcB;
    logic       usesB;
    logic       needsEarly;

    // Producers still in flight
    logic [4:0] exDest;
    logic       exRegWrite;
    logic [4:0] memDest;
    logic       memRegWrite;

    logic       stall;

    modport decode (output srcA, srcB, usesB, needsEarly, input stall);
    modport execute (output exDest, exRegWrite);
    modport memory (output memDest, memRegWrite);
    modport hazard (
        input  srcA, srcB, usesB, needsEarly,
        input  exDest, exRegWrite, memDest, memRegWrite,
        output stall
    );

endinterface

// ==== source/fetchStage.sv ====
`timescale 1ns/1ns

module fetchStage (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              run,
    input  logic                              imemWe,
    input  logic [mipsPkg::imemAddrBits-1:0]  imemAddr,
    input  logic [31:0]                       imemData,
    input  logic                              stall,
    input  logic                              redirect,
    input  logic [31:0]                       target,
    output logic [31:0]                       pc,
    output mipsPkg::ifId_t                    ifId
);
    import mipsPkg::*;

    logic [31:0] imem [imemWords];
    logic [31:0] instrWord;
    logic [31:0] pcPlus4;

    // Program load port
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign instrWord = imem[pc[imemAddrBits+1:2]];
    assign pcPlus4   = pc + 32'd4;

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (run && !stall) begin
            pc <= redirect ? target : pcPlus4;
        end
    end

    // Fetch to decode register with a bubble on redirect or when idle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ifId <= '0;
        end else if (!stall) begin
            ifId.valid   <= run && !redirect;
            ifId.pcPlus4 <= pcPlus4;
            ifId.instr   <= instrWord;
        end
    end

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::ifId_t   ifId,
    input  logic             wbValid,
    input  logic [4:0]       wbReg,
    input  logic [31:0]      wbData,
    output logic             redirect,
    output logic [31:0]      target,
    output mipsPkg::idEx_t   idEx,
    hazardIf.decode          hz
);
    import mipsPkg::*;

    logic [31:0] regFile [32];
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [31:0] rdA;
    logic [31:0] rdB;
    logic [31:0] imm;
    ctrl_t       ctrl;
    logic        usesA;
    logic        bUsed;
    logic        regDst;
    logic        isBranch;
    logic        branchNe;
    logic        isJump;
    logic        taken;

    assign rs  = ifId.instr[25:21];
    assign rt  = ifId.instr[20:16];
    assign rd  = ifId.instr[15:11];
    assign imm = {{16{ifId.instr[15]}}, ifId.instr[15:0]};

    //////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbValid) begin
            regFile[wbReg] <= wbData;
        end
    end

    // Write-first bypass with r0 held at zero
    assign rdA = (rs == 5'd0) ? '0 : (wbValid && wbReg == rs) ? wbData : regFile[rs];
    assign rdB = (rt == 5'd0) ? '0 : (wbValid && wbReg == rt) ? wbData : regFile[rt];

    //////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////
    always_comb begin
        ctrl     = '0;
        usesA    = 1'b0;
        bUsed    = 1'b0;
        regDst   = 1'b0;
        isBranch = 1'b0;
        branchNe = 1'b0;
        isJump   = 1'b0;
        case (opcode_t'(ifId.instr[31:26]))
            opRtype: begin
                usesA  = 1'b1;
                bUsed  = 1'b1;
                regDst = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct_t'(ifId.instr[5:0]))
                    fnAdd:   ctrl.aluOp = aluAdd;
                    fnSub:   ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            opAddi: begin
                usesA          = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opLw: begin
                usesA          = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opSw: begin
                usesA          = 1'b1;
                bUsed          = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBeq: begin
                usesA    = 1'b1;
                isBranch = 1'b1;
            end
            opBne: begin
                usesA    = 1'b1;
                isBranch = 1'b1;
                branchNe = 1'b1;
            end
            opJ:     isJump = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // Hazard sources stay quiet for a bubble
    assign hz.srcA       = (ifId.valid && usesA) ? rs : 5'd0;
    assign hz.srcB       = rt;
    assign hz.usesB      = ifId.valid && bUsed;
    assign hz.needsEarly = ifId.valid && isBranch;

    //////////////////////////////////////////////////
    // Branch and jump resolution
    //////////////////////////////////////////////////
    assign taken    = isBranch && ((rdA == rdB) != branchNe);
    assign redirect = ifId.valid && !hz.stall && (taken || isJump);
    assign target   = isJump ? {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00}
                             : ifId.pcPlus4 + {imm[29:0], 2'b00};

    // Decode to execute register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else begin
            idEx.valid <= ifId.valid && !hz.stall;
            idEx.ctrl  <= ctrl;
            idEx.rdA   <= rdA;
            idEx.rdB   <= rdB;
            idEx.imm   <= imm;
            idEx.dest  <= regDst ? rd : rt;
        end
    end

endmodule

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit (
    hazardIf.hazard hz
);

    logic hitA;
    logic hitB;
    logic needB;

    // True when a register is still being produced further down
    function automatic logic inFlight(
        input logic [4:0] src,
        input logic [4:0] exDest,
        input logic       exRegWrite,
        input logic [4:0] memDest,
        input logic       memRegWrite
    );
        logic exHit;
        logic memHit;
        exHit  = exRegWrite && (src == exDest);
        memHit = memRegWrite && (src == memDest);
        return (src != 5'd0) && (exHit || memHit);
    endfunction

    // Branches compare both operands in decode
    assign needB = hz.usesB || hz.needsEarly;

    assign hitA = inFlight(hz.srcA, hz.exDest, hz.exRegWrite, hz.memDest, hz.memRegWrite);
    assign hitB = needB
               && inFlight(hz.srcB, hz.exDest, hz.exRegWrite, hz.memDest, hz.memRegWrite);

    assign hz.stall = hitA || hitB;

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ns

module executeStage (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::idEx_t   idEx,
    output mipsPkg::exMem_t  exMem,
    hazardIf.execute         hz
);
    import mipsPkg::*;

    logic [31:0] aluB;
    logic [31:0] aluResult;

    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : idEx.rdB;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////
    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:  aluResult = idEx.rdA + aluB;
            aluSub:  aluResult = idEx.rdA - aluB;
            aluAnd:  aluResult = idEx.rdA & aluB;
            aluOr:   aluResult = idEx.rdA | aluB;
            aluSlt:  aluResult = {31'd0, $signed(idEx.rdA) < $signed(aluB)};
            default: aluResult = '0;
        endcase
    end

    // Producer seen by the hazard unit
    assign hz.exDest     = idEx.dest;
    assign hz.exRegWrite = idEx.valid && idEx.ctrl.regWrite;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else begin
            exMem.valid     <= idEx.valid;
            exMem.ctrl      <= idEx.ctrl;
            exMem.aluResult <= aluResult;
            exMem.storeData <= idEx.rdB;
            exMem.dest      <= idEx.dest;
        end
    end

endmodule

// ==== source/memoryStage.sv ====
`timescale 1ns/1ns

module memoryStage (
    input  logic             clk,
    input  logic             arstN,
    input  mipsPkg::exMem_t  exMem,
    output logic             wbValid,
    output logic [4:0]       wbReg,
    output logic [31:0]      wbData,
    hazardIf.memory          hz
);
    import mipsPkg::*;

    logic [31:0] dmem [dmemWords];
    logic [5:0]  wordAddr;
    logic [31:0] loadData;
    logic [31:0] result;
    memWb_t      memWb;

    // Word address from the byte address
    assign wordAddr = exMem.aluResult[7:2];

    //////////////////////////////////////////////////
    // Data memory
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < dmemWords; i++) begin
                dmem[i] <= '0;
            end
        end else if (exMem.valid && exMem.ctrl.memWrite) begin
            dmem[wordAddr] <= exMem.storeData;
        end
    end

    assign loadData = exMem.ctrl.memRead ? dmem[wordAddr] : '0;
    assign result   = exMem.ctrl.memToReg ? loadData : exMem.aluResult;

    assign hz.memDest     = exMem.dest;
    assign hz.memRegWrite = exMem.valid && exMem.ctrl.regWrite;

    // Memory to writeback register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWb <= '0;
        end else begin
            memWb.valid    <= exMem.valid;
            memWb.regWrite <= exMem.ctrl.regWrite;
            memWb.dest     <= exMem.dest;
            memWb.result   <= result;
        end
    end

    //////////////////////////////////////////////////
    // Writeback bus
    //////////////////////////////////////////////////
    assign wbValid = memWb.valid && memWb.regWrite && (memWb.dest != 5'd0);
    assign wbReg   = memWb.dest;
    assign wbData  = memWb.result;

endmodule

// ==== source/mipsCore.sv ====
`timescale 1ns/1ns

module mipsCore (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              run,
    input  logic                              imemWe,
    input  logic [mipsPkg::imemAddrBits-1:0]  imemAddr,
    input  logic [31:0]                       imemData,
    output logic [31:0]                       pc,
    output logic                              wbValid,
    output logic [4:0]                        wbReg,
    output logic [31:0]                       wbData
);
    import mipsPkg::*;

    ifId_t       ifId;
    idEx_t       idEx;
    exMem_t      exMem;
    logic        redirect;
    logic [31:0] target;

    hazardIf hzBus ();

    //////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////
    fetchStage u_fetchStage (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .stall    (hzBus.stall),
        .redirect (redirect),
        .target   (target),
        .pc       (pc),
        .ifId     (ifId)
    );

    decodeStage u_decodeStage (
        .clk      (clk),
        .arstN    (arstN),
        .ifId     (ifId),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .redirect (redirect),
        .target   (target),
        .idEx     (idEx),
        .hz       (hzBus.decode)
    );

    executeStage u_executeStage (
        .clk   (clk),
        .arstN (arstN),
        .idEx  (idEx),
        .exMem (exMem),
        .hz    (hzBus.execute)
    );

    memoryStage u_memoryStage (
        .clk     (clk),
        .arstN   (arstN),
        .exMem   (exMem),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData),
        .hz      (hzBus.memory)
    );

    // Stall on any source still in execute or memory
    hazardUnit u_hazardUnit (
        .hz (hzBus.hazard)
    );

endmodule

// ==== sim/isaModel.sv ====
package isaModel;

    import mipsPkg::*;

    // Register writes in program order, r0 writes left out
    logic [4:0]  expReg [$];
    logic [31:0] expData [$];

    //////////////////////////////////////////////////
    // Instruction-level interpreter
    //////////////////////////////////////////////////
    task automatic interpret(
        input  logic [31:0] prog [imemWords],
        input  int          maxSteps,
        output logic [31:0] haltAddr,
        output bit          halted
    );
        logic [31:0] regs [32];
        logic [31:0] mem [dmemWords];
        logic [31:0] instr;
        logic [31:0] simm;
        logic [31:0] addr;
        logic [31:0] value;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic        writes;
        int          pcIdx;
        int          nextIdx;
        expReg.delete();
        expData.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dmemWords; i++) begin
            mem[i] = '0;
        end
        pcIdx    = 0;
        halted   = 1'b0;
        haltAddr = '0;
        for (int step = 0; step < maxSteps && !halted; step++) begin
            instr   = prog[pcIdx];
            rs      = instr[25:21];
            rt      = instr[20:16];
            simm    = {{16{instr[15]}}, instr[15:0]};
            addr    = regs[rs] + simm;
            writes  = 1'b0;
            dest    = rt;
            value   = '0;
            nextIdx = pcIdx + 1;
            case (instr[31:26])
                opRtype: begin
                    writes = 1'b1;
                    dest   = instr[15:11];
                    case (instr[5:0])
                        fnAdd:   value = regs[rs] + regs[rt];
                        fnSub:   value = regs[rs] - regs[rt];
                        fnAnd:   value = regs[rs] & regs[rt];
                        fnOr:    value = regs[rs] | regs[rt];
                        fnSlt:   value = ($signed(regs[rs]) < $signed(regs[rt])) ? 32'd1 : 32'd0;
                        default: writes = 1'b0;
                    endcase
                end
                opAddi: begin
                    writes = 1'b1;
                    value  = addr;
                end
                opLw: begin
                    writes = 1'b1;
                    value  = mem[addr[7:2]];
                end
                opSw:  mem[addr[7:2]] = regs[rt];
                opBeq: if (regs[rs] == regs[rt]) nextIdx = pcIdx + 1 + $signed(simm);
                opBne: if (regs[rs] != regs[rt]) nextIdx = pcIdx + 1 + $signed(simm);
                opJ: begin
                    nextIdx = int'(instr[25:0]);
                    // A jump onto itself ends the program
                    if (nextIdx == pcIdx) begin
                        halted   = 1'b1;
                        haltAddr = 32'(pcIdx * 4);
                    end
                end
                default: writes = 1'b0;
            endcase
            if (writes && dest != 5'd0) begin
                regs[dest] = value;
                expReg.push_back(dest);
                expData.push_back(value);
            end
            pcIdx = nextIdx & (imemWords - 1);
        end
    endtask

endpackage

// ==== sim/mipsCoreTb.sv ====
`timescale 1ns/1ns

module mipsCoreTb;

    import mipsPkg::*;
    import isaModel::*;

    localparam int progLen   = 40;
    localparam int waitLimit = 2000;

    logic                    clk;
    logic                    arstN;
    logic                    run;
    logic                    imemWe;
    logic [imemAddrBits-1:0] imemAddr;
    logic [31:0]             imemData;
    logic [31:0]             pc;
    logic                    wbValid;
    logic [4:0]              wbReg;
    logic [31:0]             wbData;

    logic [31:0] progMem [imemWords];
    logic [15:0] lfsrState;
    logic [31:0] haltAddr;
    bit          modelHalted;
    int          writeCount;

    mipsCore u_mipsCore (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .pc       (pc),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////
    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            value     = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic buildProgram();
        logic [2:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  fn;
        logic [15:0] offset;
        int          skip;
        // Unused words jump onto themselves
        for (int i = 0; i < imemWords; i++) begin
            progMem[i] = {opJ, 26'(i)};
        end
        for (int i = 0; i < progLen; i++) begin
            kind   = 3'(takeBits(3));
            rs     = 5'(takeBits(3));
            rt     = 5'(takeBits(3));
            rd     = 5'(takeBits(3));
            offset = 16'(takeBits(3) * 36);
            case (kind)
                3'd2: progMem[i] = {opAddi, rs, rt, 16'(takeBits(16))};
                3'd3: progMem[i] = {opLw, 5'd0, rt, offset};
                3'd4: progMem[i] = {opSw, 5'd0, rt, offset};
                3'd5, 3'd6: begin
                    skip = 1 + int'(takeBits(2)) % 3;
                    // Keep the target at or before the final jump
                    if (i + 1 + skip > progLen) skip = progLen - 1 - i;
                    if (skip > 0) begin
                        fn = (kind == 3'd5) ? opBeq : opBne;
                        progMem[i] = {fn, rs, rt, 16'(skip)};
                    end else begin
                        progMem[i] = {opAddi, rs, rt, offset};
                    end
                end
                default: begin
                    case (takeBits(3) % 5)
                        0:       fn = fnAdd;
                        1:       fn = fnSub;
                        2:       fn = fnAnd;
                        3:       fn = fnOr;
                        default: fn = fnSlt;
                    endcase
                    progMem[i] = {opRtype, rs, rt, rd, 5'd0, fn};
                end
            endcase
        end
        progMem[progLen] = {opJ, 26'(progLen)};
    endtask

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at first failure");
    endtask

    task automatic compareWrite(
        input logic [4:0]  gotReg,
        input logic [31:0] gotData,
        input logic [4:0]  wantReg,
        input logic [31:0] wantData
    );
        if (gotReg !== wantReg || gotData !== wantData) begin
            abortRun($sformatf("error at %0t: write %0d gave r%0d=%h, expected r%0d=%h",
                               $time, writeCount, gotReg, gotData, wantReg, wantData));
        end
    endtask

    task automatic comparePc(input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            abortRun($sformatf("error at %0t: pc is %h, expected %h", $time, got, want));
        end
    endtask

    task automatic compareValid(input logic got, input logic want);
        if (got !== want) begin
            abortRun($sformatf("error at %0t: wbValid is %b, expected %b", $time, got, want));
        end
    endtask

    // Program load with run low while the core stays idle
    task automatic loadProgram();
        for (int i = 0; i < imemWords; i++) begin
            @(posedge clk);
            #5;
            imemWe   = 1'b1;
            imemAddr = imemAddrBits'(i);
            imemData = progMem[i];
            @(negedge clk);
            compareValid(wbValid, 1'b0);
            comparePc(pc, 32'd0);
        end
        @(posedge clk);
        #5;
        imemWe = 1'b0;
        run    = 1'b1;
    endtask

    task automatic collectWrites();
        int idle;
        idle = 0;
        while (writeCount < expReg.size()) begin
            @(negedge clk);
            if (wbValid) begin
                compareWrite(wbReg, wbData, expReg[writeCount], expData[writeCount]);
                writeCount++;
                idle = 0;
            end else begin
                idle++;
                if (idle >= waitLimit) begin
                    abortRun($sformatf("Timeout waiting for register write %0d of %0d",
                                       writeCount, expReg.size()));
                end
            end
        end
    endtask

    // Final jump alternates pc between its address and the bubbled fetch after it
    task automatic checkHaltLoop();
        int          cycles;
        logic [31:0] wantPc;
        cycles = 0;
        // Step past the cycle of the last expected write
        @(negedge clk);
        while (pc !== haltAddr) begin
            if (wbValid) abortRun("A register write appeared beyond the model's count");
            cycles++;
            if (cycles >= waitLimit) abortRun("Timeout waiting for pc to reach the final jump");
            @(negedge clk);
        end
        wantPc = haltAddr;
        repeat (16) begin
            comparePc(pc, wantPc);
            if (wbValid) abortRun("A register write appeared beyond the model's count");
            @(negedge clk);
            wantPc = (wantPc == haltAddr) ? haltAddr + 32'd4 : haltAddr;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        arstN      = 1'b0;
        run        = 1'b0;
        imemWe     = 1'b0;
        imemAddr   = '0;
        imemData   = '0;
        lfsrState  = 16'd89;
        writeCount = 0;

        buildProgram();
        interpret(progMem, waitLimit, haltAddr, modelHalted);
        if (!modelHalted) abortRun("The model never reached the final jump");

        repeat (2) @(posedge clk);
        #5;
        arstN = 1'b1;

        loadProgram();
        collectWrites();
        checkHaltLoop();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== mipsCore.f ====
source/mipsPkg.sv
source/hazardIf.sv
source/fetchStage.sv
source/decodeStage.sv
source/hazardUnit.sv
source/executeStage.sv
source/memoryStage.sv
source/mipsCore.sv
sim/isaModel.sv
sim/mipsCoreTb.sv
